//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= all.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD)

//--- all.f
+incdir+include
source/core_pkg.sv
source/pc.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/regs.sv
source/ctrl.sv
source/core.sv
sim/tb_clk.sv
sim/tb_core.sv

//--- include/core_cfg.svh
/*
 * Build-time constants of the three-stage core: where fetch starts after
 * reset, the instruction used as a pipeline bubble, and the register count.
 * Included by the RTL files that need them.
 */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`define CORE_NREGS 32

`endif

//--- sim/tb_clk.sv
/*
 * Clock and reset source for the core testbench.
 * 10 ns clock, reset held high for the first 4 rising edges.
 */
`timescale 1ns/10ps

module tb_clk (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1 rst_o = 1'b0; // released off the edge
	end

endmodule

//--- sim/tb_core.sv
/*
 * Testbench of the three-stage core. Runs a hand-assembled program from a
 * ROM model twice, first without and then with random memory stalls, and
 * checks stores, redirects, reset state and the illegal opcode pulse.
 */
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_core import core_pkg::*;;

	localparam int NEXP = 11;

	logic clk, rst_gen, rerun_rst, rst, rst_seen;
	instr_t instr;
	word_t data_rd;
	logic stall_load, stall_store;
	addr_t pc;
	logic instr_rd_en, mem_rd_en, mem_wr_en, illegal;
	addr_t addr_rd, addr_wr;
	word_t data_wr;

	instr_t rom [0:63];
	word_t dmem [0:63];
	addr_t exp_addr [0:NEXP-1];
	word_t exp_data [0:NEXP-1];
	logic stall_on, stalled_run;
	int errors, end_errors, store_idx, ill_count, cyc;
	addr_t prev_pc, held_addr, held_wr_addr;
	word_t held_data;
	logic held_prev, ill_prev;
	logic [1:0] held_en;

	tb_clk clkgen (.clk_o(clk), .rst_o(rst_gen));

	assign rst     = rst_gen | rerun_rst;
	assign instr   = rom[pc[7:2]];
	assign data_rd = dmem[addr_rd[7:2]]; // combinational read

	core core_inst (.clk(clk), .rst_i(rst), .instr_i(instr), .data_mem_i(data_rd),
		.stall_load_i(stall_load), .stall_store_i(stall_store), .pc_o(pc),
		.instr_rd_en_o(instr_rd_en), .mem_rd_en_o(mem_rd_en), .mem_wr_en_o(mem_wr_en),
		.addr_mem_rd_o(addr_rd), .addr_mem_wr_o(addr_wr), .data_mem_wr_o(data_wr),
		.illegal_instr_o(illegal));

	function automatic instr_t rtype(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3, reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic instr_t itype(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
		reg_addr_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic instr_t stype(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic instr_t btype(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic instr_t jtype(logic [20:0] off, reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic void set_expected(input int idx, input addr_t addr, input word_t data);
		exp_addr[idx] = addr;
		exp_data[idx] = data;
	endfunction

	task automatic load_program();
		for (int i = 0; i < 64; i++)
			rom[i] = `CORE_NOP;
		rom[0]  = itype(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);      // x1 = 5
		rom[1]  = itype(12'd7, 5'd1, 3'b000, 5'd2, 7'b0010011);      // x2 = 12
		rom[2]  = rtype(7'h20, 5'd1, 5'd2, 3'b000, 5'd3);            // x3 = 7
		rom[3]  = rtype(7'h00, 5'd2, 5'd3, 3'b100, 5'd4);            // x4 = 11
		rom[4]  = rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd5);            // slt -> 1
		rom[5]  = {20'h12345, 5'd6, 7'b0110111};                     // lui x6
		rom[6]  = rtype(7'h00, 5'd4, 5'd6, 3'b110, 5'd7);            // 0x1234500b
		rom[7]  = rtype(7'h00, 5'd2, 5'd7, 3'b111, 5'd8);            // x8 = 8
		rom[8]  = stype(12'd0, 5'd4, 5'd0);
		rom[9]  = stype(12'd4, 5'd5, 5'd0);
		rom[10] = stype(12'd8, 5'd7, 5'd0);
		rom[11] = stype(12'd12, 5'd8, 5'd0);
		rom[12] = itype(12'hffd, 5'd0, 3'b000, 5'd9, 7'b0010011);    // x9 = -3
		rom[13] = stype(12'd16, 5'd9, 5'd0);
		rom[14] = itype(12'd16, 5'd0, 3'b010, 5'd10, 7'b0000011);    // lw x10
		rom[15] = itype(12'd100, 5'd10, 3'b000, 5'd11, 7'b0010011);  // used at once
		rom[16] = stype(12'd20, 5'd11, 5'd0);
		rom[17] = itype(12'h0ff, 5'd11, 3'b100, 5'd12, 7'b0010011);  // 0x9e
		rom[18] = itype(12'h100, 5'd12, 3'b110, 5'd12, 7'b0010011);  // 0x19e
		rom[19] = itype(12'h1f0, 5'd12, 3'b111, 5'd13, 7'b0010011);  // 0x190
		rom[20] = stype(12'd24, 5'd13, 5'd0);
		rom[21] = btype(13'd8, 5'd2, 5'd1, 3'b000);                  // beq not taken
		rom[22] = stype(12'd28, 5'd1, 5'd0);
		rom[23] = btype(13'd12, 5'd2, 5'd1, 3'b001);                 // bne to 104
		rom[24] = stype(12'h100, 5'd0, 5'd0);                        // marker
		rom[25] = stype(12'h100, 5'd0, 5'd0);
		rom[26] = jtype(21'd12, 5'd15);                              // jal to 116
		rom[27] = stype(12'h100, 5'd0, 5'd0);                        // marker
		rom[28] = stype(12'h100, 5'd0, 5'd0);
		rom[29] = stype(12'd32, 5'd15, 5'd0);                        // link = 108
		rom[30] = 32'h0000_00ff;                                     // bad opcode with rd x1
		rom[31] = stype(12'd36, 5'd1, 5'd0);
		rom[32] = btype(13'd8, 5'd1, 5'd9, 3'b100);                  // blt to 136
		rom[33] = stype(12'h100, 5'd0, 5'd0);                        // marker
		rom[34] = stype(12'd40, 5'd2, 5'd0);
		rom[35] = jtype(21'd0, 5'd0);                                // spin here

		// stores worked out by hand from the program above
		set_expected(0, 32'd0, 32'd11);
		set_expected(1, 32'd4, 32'd1);
		set_expected(2, 32'd8, 32'h1234_500b);
		set_expected(3, 32'd12, 32'd8);
		set_expected(4, 32'd16, 32'hffff_fffd);
		set_expected(5, 32'd20, 32'd97);
		set_expected(6, 32'd24, 32'h190);
		set_expected(7, 32'd28, 32'd5);
		set_expected(8, 32'd32, 32'd108);
		set_expected(9, 32'd36, 32'd5); // x1 untouched
		set_expected(10, 32'd40, 32'd12);
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("Error %0t: %s", $time, msg);
	endtask

	// stall levels change 1 ns after the edge
	always @(posedge clk) begin
		word_t r;
		#1;
		r = $urandom;
		stall_load  = stall_on & r[0] & r[1];
		stall_store = stall_on & r[2] & r[3];
	end

	// reset as the DUT saw it on the last rising edge
	always @(posedge clk)
		rst_seen <= rst;

	// outputs sampled mid-cycle where they are settled
	always @(negedge clk) begin
		if (rst) begin
			cyc       = -1;
			store_idx = 0;
			ill_count = 0;
			for (int i = 0; i < 64; i++)
				dmem[i] = 32'hda7a_0000 | word_t'(i << 2);
		end else
			cyc = cyc + 1;
		if (rst_seen || cyc == 0)
			assert (pc == `CORE_RESET_PC && !instr_rd_en && !mem_rd_en && !mem_wr_en && !illegal)
				else note_error("outputs not idle around reset");
		if (!stalled_run && cyc >= 1 && cyc <= 25)
			assert (pc == addr_t'(4 * (cyc - 1)))
				else note_error($sformatf("pc %0h not sequential", pc));
		if (!stalled_run && !rst && prev_pc == 32'd96)
			assert (pc == 32'd104) else note_error("bne target missed");
		if (!stalled_run && !rst && prev_pc == 32'd108)
			assert (pc == 32'd116) else note_error("jal target missed");
		if (!stalled_run && !rst && prev_pc == 32'd132)
			assert (pc == 32'd136) else note_error("blt target missed");
		if (held_prev && !rst)
			assert ({mem_rd_en, mem_wr_en} == held_en && addr_rd == held_addr
				&& addr_wr == held_wr_addr && data_wr == held_data)
				else note_error("memory request moved during stall");
		if (illegal) begin
			assert (!ill_prev) else note_error("illegal_instr_o wider than one cycle");
			ill_count++;
		end
		if (!rst && mem_wr_en && !stall_store) begin
			dmem[addr_wr[7:2]] = data_wr;
			if (store_idx >= NEXP)
				note_error($sformatf("extra store %0h to %0h", data_wr, addr_wr));
			else
				assert (addr_wr == exp_addr[store_idx] && data_wr == exp_data[store_idx])
					else note_error($sformatf("store %0d got %0h at %0h", store_idx,
						data_wr, addr_wr));
			store_idx++;
		end
		held_prev    = !rst && ((mem_wr_en && stall_store) || (mem_rd_en && stall_load));
		held_en      = {mem_rd_en, mem_wr_en};
		held_addr    = addr_rd;
		held_wr_addr = addr_wr;
		held_data    = data_wr;
		ill_prev     = illegal;
		prev_pc      = pc;
	end

	task automatic run_program(input logic with_stalls);
		int n;
		stalled_run = with_stalls;
		if (with_stalls) begin
			@(posedge clk);
			#1 rerun_rst = 1'b1;
			repeat (4) @(posedge clk);
			#1 rerun_rst = 1'b0;
		end
		for (n = 0; n < 20 && rst; n++)
			@(posedge clk);
		if (rst) begin
			$display("timeout: reset never released");
			$display("Test FAILED");
			$finish;
		end
		@(negedge clk) stall_on = with_stalls;
		for (n = 0; n < 600 && store_idx < NEXP; n++)
			@(posedge clk);
		if (store_idx < NEXP) begin
			$display("timeout: only %0d of %0d stores seen", store_idx, NEXP);
			$display("Test FAILED");
			$finish;
		end
		@(negedge clk) stall_on = 1'b0;
		repeat (8) @(posedge clk); // catch stray stores
		if (ill_count != 1) begin
			end_errors++;
			$display("Error %0t: %0d illegal pulses in run", $time, ill_count);
		end
	endtask

	initial begin
		void'($urandom(32'h67fb));
		errors      = 0;
		end_errors  = 0;
		stall_on    = 1'b0;
		stalled_run = 1'b0;
		rerun_rst   = 1'b0;
		stall_load  = 1'b0;
		stall_store = 1'b0;
		held_prev   = 1'b0;
		ill_prev    = 1'b0;
		prev_pc     = '0;
		load_program();
		run_program(1'b0);
		run_program(1'b1);
		$display("check errors: %0d, end-of-run errors: %0d", errors, end_errors);
		if (errors == 0 && end_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- source/core.sv
/*
 * Top level of the three-stage core. Connects pc, fetch, decode, execute,
 * register file and control, and exposes the instruction and data memory
 * ports, both read combinationally.
 */
`timescale 1ns/10ps

module core import core_pkg::*; (
	input  logic   clk,
	input  logic   rst_i,
	input  instr_t instr_i,
	input  word_t  data_mem_i,
	input  logic   stall_load_i,
	input  logic   stall_store_i,
	output addr_t  pc_o,
	output logic   instr_rd_en_o,
	output logic   mem_rd_en_o,
	output logic   mem_wr_en_o,
	output addr_t  addr_mem_rd_o,
	output addr_t  addr_mem_wr_o,
	output word_t  data_mem_wr_o,
	output logic   illegal_instr_o
);

	hold_code_e hold_code;
	logic       jmp_en;
	addr_t      jmp_to;
	if_id_t     if_id;
	id_ex_t     id_ex;
	jmp_req_t   jmp_req;
	wb_t        wb;
	reg_addr_t  rs1, rs2;
	word_t      rd1_data, rd2_data;
	logic       mem_busy;

	pc core_pc (.clk(clk), .rst_i(rst_i), .hold_code_i(hold_code),
		.jmp_en_i(jmp_en), .jmp_to_i(jmp_to), .pc_o(pc_o));

	if_stage core_if (.clk(clk), .rst_i(rst_i), .hold_code_i(hold_code),
		.pc_i(pc_o), .instr_i(instr_i), .instr_rd_en_o(instr_rd_en_o), .if_id_o(if_id));

	id_stage core_id (.clk(clk), .rst_i(rst_i), .hold_code_i(hold_code),
		.if_id_i(if_id), .rd1_data_i(rd1_data), .rd2_data_i(rd2_data), .wb_i(wb),
		.rs1_o(rs1), .rs2_o(rs2), .jmp_req_o(jmp_req), .id_ex_o(id_ex),
		.illegal_instr_o(illegal_instr_o));

	ex_stage core_ex (.clk(clk), .rst_i(rst_i), .hold_code_i(hold_code),
		.id_ex_i(id_ex), .data_mem_i(data_mem_i),
		.stall_load_i(stall_load_i), .stall_store_i(stall_store_i),
		.mem_rd_en_o(mem_rd_en_o), .mem_wr_en_o(mem_wr_en_o),
		.addr_mem_rd_o(addr_mem_rd_o), .addr_mem_wr_o(addr_mem_wr_o),
		.data_mem_wr_o(data_mem_wr_o), .wb_o(wb), .mem_busy_o(mem_busy));

	regs core_regs (.clk(clk), .rst_i(rst_i), .wb_i(wb), .rs1_i(rs1), .rs2_i(rs2),
		.rd1_data_o(rd1_data), .rd2_data_o(rd2_data));

	ctrl core_ctrl (.clk(clk), .rst_i(rst_i), .jmp_req_i(jmp_req), .mem_busy_i(mem_busy),
		.hold_code_o(hold_code), .jmp_en_o(jmp_en), .jmp_to_o(jmp_to));

endmodule

//--- source/core_pkg.sv
/*
 * Types shared by all stages of the core: the meaningful widths, the ALU and
 * branch codes, the hold and control state enums and the pipeline records.
 */
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [2:0]  jmp_flag_t;

	localparam alu_op_t ALU_ADD  = 3'd0;
	localparam alu_op_t ALU_SUB  = 3'd1;
	localparam alu_op_t ALU_AND  = 3'd2;
	localparam alu_op_t ALU_OR   = 3'd3;
	localparam alu_op_t ALU_XOR  = 3'd4;
	localparam alu_op_t ALU_SLT  = 3'd5;
	localparam alu_op_t ALU_PASS = 3'd6; // result is operand b

	localparam jmp_flag_t JMP_NONE = 3'd0;
	localparam jmp_flag_t JMP_BEQ  = 3'd1;
	localparam jmp_flag_t JMP_BNE  = 3'd2;
	localparam jmp_flag_t JMP_BLT  = 3'd3;
	localparam jmp_flag_t JMP_JAL  = 3'd4;

	typedef enum logic [1:0] {HOLD_NONE, HOLD_FLUSH, HOLD_ALL} hold_code_e;
	typedef enum logic [1:0] {CTRL_BOOT, CTRL_RUN, CTRL_HOLD} ctrl_state_e;

	typedef struct packed {
		instr_t instr;
		addr_t  pc;
	} if_id_t;

	typedef struct packed {
		alu_op_t   alu_op;
		word_t     op_a;
		word_t     op_b;
		word_t     st_data;
		reg_addr_t rd;
		logic      we;
		logic      ld;
		logic      st;
	} id_ex_t;

	typedef struct packed {
		jmp_flag_t flag;
		word_t     op1;
		word_t     op2;
		addr_t     target;
	} jmp_req_t;

	typedef struct packed {
		logic      we;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

//--- source/ctrl.sv
/*
 * Pipeline control. Sequences the boot cycle after reset, freezes the pipe
 * while data memory is busy and resolves branches and jal from decode into
 * a redirect of the pc plus a flush of the fetched slot.
 */
`timescale 1ns/10ps
`include "core_cfg.svh"

module ctrl import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  jmp_req_t   jmp_req_i,
	input  logic       mem_busy_i,
	output hold_code_e hold_code_o,
	output logic       jmp_en_o,
	output addr_t      jmp_to_o
);

	ctrl_state_e state, state_q;
	logic taken;

	// hold follows the busy level in the same cycle
	assign state = (state_q == CTRL_BOOT) ? CTRL_BOOT : (mem_busy_i ? CTRL_HOLD : CTRL_RUN);

	always_ff @(posedge clk) begin
		if (rst_i)
			state_q <= CTRL_BOOT;
		else
			state_q <= (state == CTRL_BOOT) ? CTRL_RUN : state;
	end

	always_comb begin
		case (jmp_req_i.flag)
			JMP_BEQ: taken = (jmp_req_i.op1 == jmp_req_i.op2);
			JMP_BNE: taken = (jmp_req_i.op1 != jmp_req_i.op2);
			JMP_BLT: taken = ($signed(jmp_req_i.op1) < $signed(jmp_req_i.op2));
			JMP_JAL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		hold_code_o = HOLD_NONE;
		jmp_en_o    = 1'b0;
		jmp_to_o    = jmp_req_i.target;
		case (state)
			CTRL_BOOT: begin
				hold_code_o = HOLD_FLUSH; // no fetch, pc kept at reset address
				jmp_en_o    = 1'b1;
				jmp_to_o    = `CORE_RESET_PC;
			end
			CTRL_HOLD: hold_code_o = HOLD_ALL;
			default: begin
				if (taken) begin
					hold_code_o = HOLD_FLUSH; // drop the word fetched behind it
					jmp_en_o    = 1'b1;
				end
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (rst_i)
		jmp_en_o |-> jmp_to_o[1:0] == 2'b00);

endmodule

//--- source/ex_stage.sv
/*
 * Execute stage. Runs the ALU, drives the data memory request for loads and
 * stores, reports a busy memory to ctrl and builds the write-back record
 * that goes to the register file and back to decode for forwarding.
 */
`timescale 1ns/10ps

module ex_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  hold_code_e hold_code_i,
	input  id_ex_t     id_ex_i,
	input  word_t      data_mem_i,
	input  logic       stall_load_i,
	input  logic       stall_store_i,
	output logic       mem_rd_en_o,
	output logic       mem_wr_en_o,
	output addr_t      addr_mem_rd_o,
	output addr_t      addr_mem_wr_o,
	output word_t      data_mem_wr_o,
	output wb_t        wb_o,
	output logic       mem_busy_o
);

	word_t alu_res;

	always_comb begin
		case (id_ex_i.alu_op)
			ALU_ADD:  alu_res = id_ex_i.op_a + id_ex_i.op_b;
			ALU_SUB:  alu_res = id_ex_i.op_a - id_ex_i.op_b;
			ALU_AND:  alu_res = id_ex_i.op_a & id_ex_i.op_b;
			ALU_OR:   alu_res = id_ex_i.op_a | id_ex_i.op_b;
			ALU_XOR:  alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
			ALU_SLT:  alu_res = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
			ALU_PASS: alu_res = id_ex_i.op_b;
			default:  alu_res = '0;
		endcase
	end

	// loads and stores use the adder for the address
	assign mem_rd_en_o   = id_ex_i.ld;
	assign mem_wr_en_o   = id_ex_i.st;
	assign addr_mem_rd_o = alu_res;
	assign addr_mem_wr_o = alu_res;
	assign data_mem_wr_o = id_ex_i.st_data;

	assign mem_busy_o = (id_ex_i.ld && stall_load_i) || (id_ex_i.st && stall_store_i);

	assign wb_o.we   = id_ex_i.we && !mem_busy_o; // write lands when memory answers
	assign wb_o.rd   = id_ex_i.rd;
	assign wb_o.data = id_ex_i.ld ? data_mem_i : alu_res;

	assert property (@(posedge clk) disable iff (rst_i)
		(mem_rd_en_o || mem_wr_en_o) |-> alu_res[1:0] == 2'b00);

	// a held request must look the same to memory on the next cycle
	assert property (@(posedge clk) disable iff (rst_i)
		(hold_code_i == HOLD_ALL && (mem_rd_en_o || mem_wr_en_o)) |=>
		$stable({mem_rd_en_o, mem_wr_en_o, addr_mem_rd_o, addr_mem_wr_o, data_mem_wr_o}));

endmodule

//--- source/id_stage.sv
/*
 * Decode stage. Splits the instruction from IF/ID, builds its immediate,
 * forwards the result of the instruction in EX, hands branch operands to
 * ctrl and registers the decoded operation into ID/EX.
 */
`timescale 1ns/10ps

module id_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  hold_code_e hold_code_i,
	input  if_id_t     if_id_i,
	input  word_t      rd1_data_i,
	input  word_t      rd2_data_i,
	input  wb_t        wb_i,
	output reg_addr_t  rs1_o,
	output reg_addr_t  rs2_o,
	output jmp_req_t   jmp_req_o,
	output id_ex_t     id_ex_o,
	output logic       illegal_instr_o
);

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	instr_t ins;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_j, imm_u;
	word_t rs1_val, rs2_val;
	id_ex_t id_ex_d, id_ex_q;
	logic illegal, illegal_q;

	assign ins    = if_id_i.instr;
	assign funct3 = ins[14:12];
	assign funct7 = ins[31:25];
	assign rs1_o  = ins[19:15];
	assign rs2_o  = ins[24:20];

	assign imm_i = {{20{ins[31]}}, ins[31:20]};
	assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
	assign imm_u = {ins[31:12], 12'b0};

	// EX result overrides the file, x0 never forwarded
	assign rs1_val = (wb_i.we && wb_i.rd != '0 && wb_i.rd == rs1_o) ? wb_i.data : rd1_data_i;
	assign rs2_val = (wb_i.we && wb_i.rd != '0 && wb_i.rd == rs2_o) ? wb_i.data : rd2_data_i;

	always_comb begin
		illegal            = 1'b0;
		id_ex_d.alu_op     = ALU_ADD;
		id_ex_d.op_a       = rs1_val;
		id_ex_d.op_b       = rs2_val;
		id_ex_d.st_data    = rs2_val;
		id_ex_d.rd         = ins[11:7];
		id_ex_d.we         = 1'b0;
		id_ex_d.ld         = 1'b0;
		id_ex_d.st         = 1'b0;
		jmp_req_o.flag     = JMP_NONE;
		jmp_req_o.op1      = rs1_val;
		jmp_req_o.op2      = rs2_val;
		jmp_req_o.target   = if_id_i.pc + imm_b;
		case (ins[6:0])
			OPC_OP: begin
				id_ex_d.we = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: id_ex_d.alu_op = ALU_ADD;
					{7'h20, 3'b000}: id_ex_d.alu_op = ALU_SUB;
					{7'h00, 3'b111}: id_ex_d.alu_op = ALU_AND;
					{7'h00, 3'b110}: id_ex_d.alu_op = ALU_OR;
					{7'h00, 3'b100}: id_ex_d.alu_op = ALU_XOR;
					{7'h00, 3'b010}: id_ex_d.alu_op = ALU_SLT;
					default:         illegal = 1'b1;
				endcase
			end
			OPC_IMM: begin
				id_ex_d.we   = 1'b1;
				id_ex_d.op_b = imm_i;
				case (funct3)
					3'b000:  id_ex_d.alu_op = ALU_ADD;
					3'b100:  id_ex_d.alu_op = ALU_XOR;
					3'b110:  id_ex_d.alu_op = ALU_OR;
					3'b111:  id_ex_d.alu_op = ALU_AND;
					default: illegal = 1'b1;
				endcase
			end
			OPC_LUI: begin
				id_ex_d.we     = 1'b1;
				id_ex_d.alu_op = ALU_PASS;
				id_ex_d.op_b   = imm_u;
			end
			OPC_LOAD: begin
				id_ex_d.we   = 1'b1;
				id_ex_d.ld   = 1'b1;
				id_ex_d.op_b = imm_i;
				illegal      = (funct3 != 3'b010); // lw only
			end
			OPC_STORE: begin
				id_ex_d.st   = 1'b1;
				id_ex_d.op_b = imm_s;
				illegal      = (funct3 != 3'b010); // sw only
			end
			OPC_BRANCH: begin
				case (funct3)
					3'b000:  jmp_req_o.flag = JMP_BEQ;
					3'b001:  jmp_req_o.flag = JMP_BNE;
					3'b100:  jmp_req_o.flag = JMP_BLT;
					default: illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				jmp_req_o.flag   = JMP_JAL;
				jmp_req_o.target = if_id_i.pc + imm_j;
				id_ex_d.we       = 1'b1;
				id_ex_d.alu_op   = ALU_PASS; // link value rides on operand b
				id_ex_d.op_b     = if_id_i.pc + 32'd4;
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			id_ex_d        = '0; // executes as a bubble
			jmp_req_o.flag = JMP_NONE;
		end
	end

	// a flush only drops the IF slot, the branch in ID still moves on
	always_ff @(posedge clk) begin
		if (rst_i) begin
			id_ex_q   <= '0;
			illegal_q <= 1'b0;
		end else begin
			illegal_q <= illegal && hold_code_i != HOLD_ALL; // one pulse per instruction
			if (hold_code_i != HOLD_ALL)
				id_ex_q <= id_ex_d;
		end
	end

	assign id_ex_o         = id_ex_q;
	assign illegal_instr_o = illegal_q;

endmodule

//--- source/if_stage.sv
/*
 * Fetch side of the IF/ID boundary. Captures the word returned for the
 * current pc, swaps in a NOP when ctrl flushes the slot and keeps the slot
 * while the pipeline is held.
 */
`timescale 1ns/10ps
`include "core_cfg.svh"

module if_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  hold_code_e hold_code_i,
	input  addr_t      pc_i,
	input  instr_t     instr_i,
	output logic       instr_rd_en_o,
	output if_id_t     if_id_o
);

	if_id_t slot_q;

	always_ff @(posedge clk) begin
		if (rst_i || hold_code_i == HOLD_FLUSH) begin
			slot_q.instr <= `CORE_NOP; // fetched word is dropped
			slot_q.pc    <= pc_i;
		end else if (hold_code_i == HOLD_NONE) begin
			slot_q.instr <= instr_i;
			slot_q.pc    <= pc_i;
		end
	end

	// no fetch is needed when the word would be dropped or held
	assign instr_rd_en_o = (hold_code_i == HOLD_NONE);
	assign if_id_o       = slot_q;

endmodule

//--- source/pc.sv
/*
 * Program counter. Steps one word per cycle, takes the redirect target
 * from ctrl and freezes while the whole pipeline is held.
 */
`timescale 1ns/10ps
`include "core_cfg.svh"

module pc import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  hold_code_e hold_code_i,
	input  logic       jmp_en_i,
	input  addr_t      jmp_to_i,
	output addr_t      pc_o
);

	addr_t pc_q;

	always_ff @(posedge clk) begin
		if (rst_i)
			pc_q <= `CORE_RESET_PC;
		else if (jmp_en_i)
			pc_q <= jmp_to_i; // taken branch, jal or boot
		else if (hold_code_i != HOLD_ALL)
			pc_q <= pc_q + 32'd4;
	end

	assign pc_o = pc_q;

	// ctrl must never redirect a frozen pipe
	assert property (@(posedge clk) disable iff (rst_i)
		!(jmp_en_i && hold_code_i == HOLD_ALL));

endmodule

//--- source/regs.sv
/*
 * General register file. x0 is hard-wired to zero, two combinational read
 * ports serve decode and the single write port takes the EX record.
 */
`timescale 1ns/10ps
`include "core_cfg.svh"

module regs import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  wb_t       wb_i,
	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,
	output word_t     rd1_data_o,
	output word_t     rd2_data_o
);

	word_t regs_q [1:`CORE_NREGS-1];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 1; i < `CORE_NREGS; i++)
				regs_q[i] <= '0;
		end else if (wb_i.we && wb_i.rd != '0) begin
			regs_q[wb_i.rd] <= wb_i.data;
		end
	end

	assign rd1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rd2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule
